//--- bnn_classifier.f
src/bnn_pkg.sv
src/bnn_fifo.sv
src/bnn_hidden_layer.sv
src/bnn_output_layer.sv
src/bnn_axil_regs.sv
src/bnn_classifier.sv
testbench/tb_bnn_classifier.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -j 0 \
  --top-module tb_bnn_classifier -o sim_bnn -f bnn_classifier.f

# The log decides the result, so a non-zero exit from the model is tolerated here
./obj_dir/sim_bnn > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  exit 1
fi
grep -q "SIMULATION PASSED" sim.log

//--- testbench/tb_bnn_classifier.sv
module tb_bnn_classifier import bnn_pkg::*; ();

  localparam int CLK_PERIOD = 8;
  localparam int VEC_BUDGET = 40;
  localparam int TIMEOUT    = VEC_BUDGET * (HIDDEN_CNT + CLASS_CNT + 30) * CLK_PERIOD;

  logic clk, rst;
  logic [AXI_ADDR_W-1:0] awaddr, araddr;
  logic [AXI_DATA_W-1:0] wdata, rdata;
  logic [3:0] wstrb;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  logic [1:0] bresp, rresp;

  result_t exp_q[$];  // One entry per accepted feature write
  logic [AXI_ADDR_W-1:0] rd_addr_q = ADDR_STATUS;
  int checked = 0;

  bnn_classifier i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic stop_run();
    $display("SIMULATION FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_result(result_t exp, result_t act);
    if (act !== exp) begin
      $display("** Error: result: expected hidden=%h cls=%h, got hidden=%h cls=%h",
               exp.hidden, exp.cls, act.hidden, act.cls);
      stop_run();
    end
  endtask

  task automatic check_resp(string name, logic [1:0] exp, logic [1:0] act);
    if (act !== exp) begin
      $display("** Error: %s: expected %h, got %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_status(string name, logic [AXI_DATA_W-1:0] exp,
                              logic [AXI_DATA_W-1:0] act);
    if (act !== exp) begin
      $display("** Error: %s: expected %h, got %h", name, exp, act);
      stop_run();
    end
  endtask

  // Sign of the signed feature sum per neuron, then agreement count per class
  function automatic result_t predict_result(feat_vec_t feat);
    result_t r;
    int sum;
    int score;
    int best;
    logic [FEAT_BITS-1:0] fv;
    for (int n = 0; n < HIDDEN_CNT; n++) begin
      sum = 0;
      for (int i = 0; i < FEAT_CNT; i++) begin
        fv = feat[i*FEAT_BITS +: FEAT_BITS];
        if (HIDDEN_WEIGHTS[n*FEAT_CNT + i])
          sum = sum + int'(fv);
        else
          sum = sum - int'(fv);
      end
      r.hidden[n] = sum >= 0;
    end
    best  = -1;
    r.cls = '0;
    for (int k = 0; k < CLASS_CNT; k++) begin
      score = 0;
      for (int n = 0; n < HIDDEN_CNT; n++)
        if (r.hidden[n] == OUTPUT_WEIGHTS[k*HIDDEN_CNT + n])
          score++;
      if (score > best) begin  // Lowest index keeps a tie
        best  = score;
        r.cls = class_t'(k);
      end
    end
    return r;
  endfunction

  task automatic axil_write(input logic [AXI_ADDR_W-1:0] addr, input logic [AXI_DATA_W-1:0] data,
                            input int bdelay, output logic [1:0] resp);
    @(posedge clk);
    #1;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    do @(posedge clk); while (!(awready && wready));
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    for (int i = 0; i < bdelay; i++) begin
      @(posedge clk);
      #1;
    end
    bready = 1'b1;
    do @(posedge clk); while (!bvalid);
    resp = bresp;
    #1;
    bready = 1'b0;
  endtask

  task automatic axil_read(input logic [AXI_ADDR_W-1:0] addr, input int rdelay,
                           output logic [AXI_DATA_W-1:0] data, output logic [1:0] resp);
    @(posedge clk);
    #1;
    araddr  = addr;
    arvalid = 1'b1;
    do @(posedge clk); while (!arready);
    #1;
    arvalid = 1'b0;
    for (int i = 0; i < rdelay; i++) begin
      @(posedge clk);
      #1;
    end
    rready = 1'b1;
    do @(posedge clk); while (!rvalid);
    data = rdata;
    resp = rresp;
    #1;
    rready = 1'b0;
  endtask

  task automatic write_feature(feat_vec_t feat, int bdelay, output logic [1:0] resp);
    axil_write(ADDR_FEATURE, feat, bdelay, resp);
    if (resp == RESP_OKAY)
      exp_q.push_back(predict_result(feat));
  endtask

  task automatic read_result(int rdelay);
    logic [AXI_DATA_W-1:0] data;
    logic [1:0] resp;
    axil_read(ADDR_RESULT, rdelay, data, resp);
    check_resp("rresp", RESP_OKAY, resp);
  endtask

  task automatic wait_for_result();
    logic [AXI_DATA_W-1:0] status;
    logic [1:0] resp;
    do axil_read(ADDR_STATUS, 0, status, resp); while (!status[0]);
  endtask

  task automatic drain_results();
    logic [AXI_DATA_W-1:0] status;
    logic [1:0] resp;
    while (exp_q.size() > 0) begin
      wait_for_result();
      read_result(0);
    end
    axil_read(ADDR_STATUS, 0, status, resp);
    check_status("status", '0, status);
  endtask

  // Compares every successful result read with the oldest expected entry
  always @(posedge clk) begin
    result_t act;
    if (rvalid && rready && rd_addr_q == ADDR_RESULT && rresp == RESP_OKAY) begin
      if (exp_q.size() == 0) begin
        $display("A result was read although no accepted write was waiting for one");
        stop_run();
      end
      act.cls    = rdata[CLASS_W-1:0];
      act.hidden = rdata[RES_HIDDEN_LSB +: HIDDEN_CNT];
      check_result(exp_q.pop_front(), act);
      checked++;
    end
    if (arvalid && arready)
      rd_addr_q = araddr;
  end

  initial begin
    #(TIMEOUT);
    $display("Timeout: the tests did not finish within %0d time units", TIMEOUT);
    stop_run();
  end

  initial begin
    logic [AXI_DATA_W-1:0] data;
    logic [AXI_DATA_W-1:0] status;
    logic [1:0] resp;
    feat_vec_t feat;
    int n_written;
    int n_dropped;
    void'($urandom(48969));
    rst     = 1'b1;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = 4'hf;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    axil_read(ADDR_STATUS, 0, data, resp);
    check_resp("rresp", RESP_OKAY, resp);
    check_status("status", '0, data);
    axil_read(ADDR_RESULT, 0, data, resp);
    check_resp("rresp", RESP_SLVERR, resp);
    check_status("rdata", '0, data);

    for (int i = 0; i < 3; i++) begin  // All zero, all max, random
      feat = (i == 0) ? '0 : (i == 1) ? '1 : feat_vec_t'($urandom);
      write_feature(feat, 0, resp);
      check_resp("bresp", RESP_OKAY, resp);
      wait_for_result();
      read_result(0);
    end

    n_written = 0;
    while (n_written < 20) begin
      axil_read(ADDR_STATUS, 0, status, resp);
      if (!status[1]) begin
        write_feature(feat_vec_t'($urandom), 0, resp);
        check_resp("bresp", RESP_OKAY, resp);
        n_written++;
      end else if (status[0]) begin
        read_result(0);  // Frees room further up the chain
      end
    end
    drain_results();

    n_dropped = 0;
    for (int i = 0; i < 12; i++) begin
      axil_read(ADDR_STATUS, 0, status, resp);
      write_feature(feat_vec_t'($urandom), 0, resp);
      if (resp == RESP_SLVERR) begin
        if (!status[1]) begin
          $display("A feature write was refused while the feature FIFO was not full");
          stop_run();
        end
        n_dropped++;
      end else begin
        check_resp("bresp", RESP_OKAY, resp);
      end
    end
    if (n_dropped == 0) begin
      $display("The feature FIFO never filled during the back-pressure test");
      stop_run();
    end
    drain_results();

    for (int op = 0; op < 24; op++) begin
      repeat ($urandom_range(0, 3)) @(posedge clk);
      if ($urandom_range(0, 1) == 1) begin
        write_feature(feat_vec_t'($urandom), int'($urandom_range(0, 3)), resp);
      end else begin
        axil_read(ADDR_STATUS, 0, status, resp);
        if (status[0])
          read_result(int'($urandom_range(0, 3)));
      end
    end
    drain_results();

    $display("%0d results checked", checked);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- src/bnn_classifier.sv
module bnn_classifier import bnn_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [AXI_ADDR_W-1:0] awaddr,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [AXI_DATA_W-1:0] wdata,
  input  logic [3:0]            wstrb,
  input  logic                  wvalid,
  output logic                  wready,
  output logic [1:0]            bresp,
  output logic                  bvalid,
  input  logic                  bready,
  input  logic [AXI_ADDR_W-1:0] araddr,
  input  logic                  arvalid,
  output logic                  arready,
  output logic [AXI_DATA_W-1:0] rdata,
  output logic [1:0]            rresp,
  output logic                  rvalid,
  input  logic                  rready
);

  logic        feat_push, feat_full, feat_pop, feat_empty;
  feat_vec_t   feat_data, feat_head;
  logic        hidden_push, hidden_full, hidden_pop, hidden_empty;
  hidden_vec_t hidden_data, hidden_head;
  logic        result_push, result_full, result_pop, result_empty;
  result_t     result_data, result_head;

  bnn_axil_regs i_regs (
    .clk, .rst,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .feat_push, .feat_data, .feat_full,
    .result_pop, .result_data(result_head), .result_empty
  );

  bnn_fifo #(.payload_t(feat_vec_t)) feat_fifo (
    .clk, .rst,
    .push(feat_push), .push_data(feat_data), .full(feat_full),
    .pop(feat_pop), .pop_data(feat_head), .empty(feat_empty)
  );

  bnn_hidden_layer i_hidden (
    .clk, .rst,
    .feat_in(feat_head), .feat_empty, .feat_pop,
    .hidden_out(hidden_data), .hidden_full, .hidden_push
  );

  bnn_fifo #(.payload_t(hidden_vec_t)) hidden_fifo (
    .clk, .rst,
    .push(hidden_push), .push_data(hidden_data), .full(hidden_full),
    .pop(hidden_pop), .pop_data(hidden_head), .empty(hidden_empty)
  );

  bnn_output_layer i_output (
    .clk, .rst,
    .hidden_in(hidden_head), .hidden_empty, .hidden_pop,
    .result_out(result_data), .result_full, .result_push
  );

  bnn_fifo #(.payload_t(result_t)) result_fifo (
    .clk, .rst,
    .push(result_push), .push_data(result_data), .full(result_full),
    .pop(result_pop), .pop_data(result_head), .empty(result_empty)
  );

endmodule

//--- src/bnn_axil_regs.sv
module bnn_axil_regs import bnn_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [AXI_ADDR_W-1:0] awaddr,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [AXI_DATA_W-1:0] wdata,
  input  logic [3:0]            wstrb,
  input  logic                  wvalid,
  output logic                  wready,
  output logic [1:0]            bresp,
  output logic                  bvalid,
  input  logic                  bready,
  input  logic [AXI_ADDR_W-1:0] araddr,
  input  logic                  arvalid,
  output logic                  arready,
  output logic [AXI_DATA_W-1:0] rdata,
  output logic [1:0]            rresp,
  output logic                  rvalid,
  input  logic                  rready,
  output logic                  feat_push,
  output feat_vec_t             feat_data,
  input  logic                  feat_full,
  output logic                  result_pop,
  input  result_t               result_data,
  input  logic                  result_empty
);

  logic                  wr_fire;
  logic                  wr_feat;
  logic                  rd_fire;
  logic [AXI_DATA_W-1:0] rdata_next;
  logic [1:0]            rresp_next;

  // Address and data are taken together; wstrb is not used
  assign wr_fire   = awvalid && wvalid && !bvalid;
  assign awready   = wr_fire;
  assign wready    = wr_fire;
  assign wr_feat   = wr_fire && awaddr == ADDR_FEATURE;
  assign feat_push = wr_feat && !feat_full;  // Dropped when full
  assign feat_data = wdata;

  assign arready    = !rvalid;
  assign rd_fire    = arvalid && !rvalid;
  assign result_pop = rd_fire && araddr == ADDR_RESULT && !result_empty;

  always_comb begin
    rdata_next = '0;
    rresp_next = RESP_OKAY;
    case (araddr)
      ADDR_STATUS: begin
        rdata_next[0] = !result_empty;
        rdata_next[1] = feat_full;
      end
      ADDR_RESULT: begin
        if (result_empty) begin
          rresp_next = RESP_SLVERR;
        end else begin
          rdata_next[CLASS_W-1:0]                   = result_data.cls;
          rdata_next[RES_HIDDEN_LSB +: HIDDEN_CNT] = result_data.hidden;
        end
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bvalid <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      if (wr_fire)
        bvalid <= 1'b1;
      else if (bready)
        bvalid <= 1'b0;
      if (rd_fire)
        rvalid <= 1'b1;
      else if (rready)
        rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire)
      bresp <= (wr_feat && feat_full) ? RESP_SLVERR : RESP_OKAY;
    if (rd_fire) begin
      rdata <= rdata_next;
      rresp <= rresp_next;
    end
  end

  a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
    bvalid && !bready |=> bvalid && $stable(bresp));
  a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
    rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

//--- src/bnn_output_layer.sv
module bnn_output_layer import bnn_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  hidden_vec_t hidden_in,
  input  logic        hidden_empty,
  output logic        hidden_pop,
  output result_t     result_out,
  input  logic        result_full,
  output logic        result_push
);

  logic                    busy;
  logic [CLASS_CNT_W-1:0]  cls_cnt;
  logic                    last;
  hidden_vec_t             hidden_reg;
  hidden_vec_t             agree;
  logic [HIDDEN_CNT_W-1:0] score;
  logic [HIDDEN_CNT_W-1:0] best_score;
  class_t                  best_cls;

  assign last  = cls_cnt == CLASS_CNT_W'(CLASS_CNT);
  assign agree = hidden_reg ~^ OUTPUT_WEIGHTS[cls_cnt[CLASS_W-1:0]*HIDDEN_CNT +: HIDDEN_CNT];

  always_comb begin
    score = '0;
    for (int n = 0; n < HIDDEN_CNT; n++)
      score = score + agree[n];
  end

  assign hidden_pop  = !busy && !hidden_empty;
  assign result_push = busy && last && !result_full;
  assign result_out  = '{hidden: hidden_reg, cls: best_cls};

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy    <= 1'b0;
      cls_cnt <= '0;
    end else if (hidden_pop) begin
      busy    <= 1'b1;
      cls_cnt <= '0;
    end else if (busy) begin
      if (!last)
        cls_cnt <= cls_cnt + 1'b1;
      else if (!result_full)
        busy <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (hidden_pop) begin
      hidden_reg <= hidden_in;
      best_score <= '0;
      best_cls   <= '0;
    end else if (busy && !last && score > best_score) begin
      best_score <= score;  // Strictly higher, so ties keep the lower class
      best_cls   <= cls_cnt[CLASS_W-1:0];
    end
  end

endmodule

//--- src/bnn_hidden_layer.sv
module bnn_hidden_layer import bnn_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  feat_vec_t   feat_in,
  input  logic        feat_empty,
  output logic        feat_pop,
  output hidden_vec_t hidden_out,
  input  logic        hidden_full,
  output logic        hidden_push
);

  logic                    busy;
  logic [HIDDEN_CNT_W-1:0] cnt;   // Neuron under evaluation
  logic                    last;
  feat_vec_t               feat_reg;
  hidden_vec_t             hidden_reg;
  logic [FEAT_CNT-1:0]     slice;
  logic signed [SUM_W-1:0] sum;

  assign last  = cnt == HIDDEN_CNT_W'(HIDDEN_CNT);
  assign slice = HIDDEN_WEIGHTS[cnt[HIDDEN_IDX_W-1:0]*FEAT_CNT +: FEAT_CNT];

  // xnor with the weight gives +f for a 1 and -f-1 for a 0,
  // so each 0 weight adds one back
  always_comb begin
    logic signed [FEAT_BITS:0] moment;
    sum = '0;
    for (int i = 0; i < FEAT_CNT; i++) begin
      moment = {(FEAT_BITS+1){slice[i]}} ~^ {1'b0, feat_reg[i*FEAT_BITS +: FEAT_BITS]};
      sum = sum + moment;
      if (!slice[i])
        sum = sum + 1;
    end
  end

  assign feat_pop    = !busy && !feat_empty;
  assign hidden_push = busy && last && !hidden_full;
  assign hidden_out  = hidden_reg;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy <= 1'b0;
      cnt  <= '0;
    end else if (feat_pop) begin
      busy <= 1'b1;
      cnt  <= '0;
    end else if (busy) begin
      if (!last)
        cnt <= cnt + 1'b1;
      else if (!hidden_full)
        busy <= 1'b0;  // Vector handed on
    end
  end

  always_ff @(posedge clk) begin
    if (feat_pop)
      feat_reg <= feat_in;
    if (busy && !last)
      hidden_reg <= {~sum[SUM_W-1], hidden_reg[HIDDEN_CNT-1:1]};  // Neuron 0 lands at bit 0
  end

  a_cnt_range: assert property (@(posedge clk) disable iff (rst)
    cnt <= HIDDEN_CNT_W'(HIDDEN_CNT));

endmodule

//--- src/bnn_fifo.sv
module bnn_fifo import bnn_pkg::*; #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = FIFO_DEPTH
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     push,
  input  payload_t push_data,
  output logic     full,
  input  logic     pop,
  output payload_t pop_data,
  output logic     empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  assign full     = count == CNT_W'(DEPTH);
  assign empty    = count == '0;
  assign pop_data = mem[rd_ptr];  // Head entry, valid while not empty

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr] <= push_data;
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (rst) push |-> !full);
  a_no_underflow: assert property (@(posedge clk) disable iff (rst) pop |-> !empty);

endmodule

//--- src/bnn_pkg.sv
package bnn_pkg;

  localparam int FEAT_CNT   = 8;
  localparam int FEAT_BITS  = 4;
  localparam int HIDDEN_CNT = 16;
  localparam int CLASS_CNT  = 4;
  localparam int FIFO_DEPTH = 4;

  // Neuron n uses bits [n*FEAT_CNT +: FEAT_CNT]
  localparam logic [HIDDEN_CNT*FEAT_CNT-1:0] HIDDEN_WEIGHTS =
    128'h5a3c_96e1_0ff0_c3a5_7e18_b24d_e187_39c6;
  // Class k uses bits [k*HIDDEN_CNT +: HIDDEN_CNT]
  localparam logic [CLASS_CNT*HIDDEN_CNT-1:0] OUTPUT_WEIGHTS = 64'hf0c3_5a96_0f3c_a569;

  localparam int HIDDEN_IDX_W = $clog2(HIDDEN_CNT);
  localparam int HIDDEN_CNT_W = $clog2(HIDDEN_CNT + 1);  // also holds a class score
  localparam int CLASS_W      = $clog2(CLASS_CNT);
  localparam int CLASS_CNT_W  = $clog2(CLASS_CNT + 1);
  localparam int SUM_W        = FEAT_BITS + $clog2(FEAT_CNT) + 2;

  localparam int AXI_ADDR_W     = 4;
  localparam int AXI_DATA_W     = 32;
  localparam int RES_HIDDEN_LSB = 8;  // hidden vector position in the result word

  localparam logic [AXI_ADDR_W-1:0] ADDR_FEATURE = 4'h0;
  localparam logic [AXI_ADDR_W-1:0] ADDR_STATUS  = 4'h4;
  localparam logic [AXI_ADDR_W-1:0] ADDR_RESULT  = 4'h8;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef logic [FEAT_CNT*FEAT_BITS-1:0] feat_vec_t;
  typedef logic [HIDDEN_CNT-1:0]         hidden_vec_t;
  typedef logic [CLASS_W-1:0]            class_t;

  typedef struct packed {
    hidden_vec_t hidden;
    class_t      cls;
  } result_t;

endpackage
